//--- src.f
+incdir+verification
logic/fxp_pkg.sv
logic/fft_pkg.sv
logic/twiddle_rom.sv
logic/butterfly_array.sv
logic/fft_pease_core.sv
logic/sample_framer.sv
logic/power_spectrum.sv
logic/spectrum_top.sv
verification/spectrum_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= spectrum_tb
FILE_LIST ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal -j 0
PASS_MSG  ?= Test completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- verification/fft_model.svh
`ifndef FFT_MODEL_SVH
`define FFT_MODEL_SVH

localparam logic [31:0] LFSR_SEED = 32'h1b13af81;
localparam logic [31:0] LFSR_TAPS = 32'h80200003;  // x^32 + x^22 + x^2 + x + 1.
localparam real PI = 3.14159265358979;

logic [31:0] lfsr_state = LFSR_SEED;

// Galois LFSR, one step per bit taken.
function automatic int take_bits(input int n);
  int v;
  v = 0;
  for (int b = 0; b < n; b++) begin
    v = (v << 1) | int'(lfsr_state[0]);
    lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ LFSR_TAPS : lfsr_state >> 1;
  end
  return v;
endfunction

// 12-bit two's complement sample.
function automatic int random_sample();
  int raw;
  raw = take_bits(12);
  return (raw >= 2048) ? raw - 4096 : raw;
endfunction

// Bin power in DUT units, |X|^2 scaled by 2^FRAC_W.
function automatic real dft_power(input int x[N_SAMPLES], input int k);
  real re;
  real im;
  real ang;
  re = 0.0;
  im = 0.0;
  for (int j = 0; j < N_SAMPLES; j++) begin
    ang = 2.0 * PI * j * k / N_SAMPLES;
    re += x[j] * $cos(ang);
    im -= x[j] * $sin(ang);
  end
  return (re * re + im * im) * (2.0 ** FRAC_W);
endfunction

// Twiddle rounding allowance.
function automatic bit within_tolerance(input real got, input real want, input real peak);
  real diff;
  diff = (got > want) ? got - want : want - got;
  return diff <= 0.001 * peak + 4.0;
endfunction

`endif

//--- verification/spectrum_tb.sv
`default_nettype none

module spectrum_tb
  import fxp_pkg::*;
  import fft_pkg::*;
();

  localparam int N_TESTS = 6;
  localparam int WATCHDOG_CYCLES = N_TESTS * 40 + 100;
  localparam int LATENCY = 6;  // 8th strobe to bin 0, empty pipeline.

  logic    clk;
  logic    reset;
  sample_t sample;
  logic    sample_strobe;
  bin_t    bin;
  logic    bin_val;
  logic    overflow;

  int     errors = 0;
  int     checks = 0;
  int     cycle = 0;
  bin_t   rx_q[$];
  real    exp_q[$];
  real    peak_q[$];
  longint last_pow[N_SAMPLES];

  `include "fft_model.svh"

  spectrum_top UUT (
    .clk          (clk),
    .reset        (reset),
    .sample       (sample),
    .sample_strobe(sample_strobe),
    .bin          (bin),
    .bin_val      (bin_val),
    .overflow     (overflow)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  always @(negedge clk) begin
    if (bin_val) rx_q.push_back(bin);  // Registered outputs, settled here.
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, DUT stopped responding", WATCHDOG_CYCLES);
    $display("Test failed");
    $finish;
  end

  task automatic do_reset();
    reset = 1'b1;
    repeat (4) @(negedge clk);
    reset = 1'b0;
    rx_q.delete();
    exp_q.delete();
    peak_q.delete();
  endtask

  // Queues the expected powers, then strobes one sample every gap cycles.
  task automatic send_frame(input int x[N_SAMPLES], input int gap);
    real p[N_SAMPLES];
    real peak;
    peak = 0.0;
    for (int k = 0; k < N_SAMPLES; k++) begin
      p[k] = dft_power(x, k);
      if (p[k] > peak) peak = p[k];
    end
    for (int k = 0; k < N_SAMPLES; k++) begin
      exp_q.push_back(p[k]);
      peak_q.push_back(peak);
    end
    for (int j = 0; j < N_SAMPLES; j++) begin
      @(negedge clk);
      sample = sample_t'(x[j]);
      sample_strobe = 1'b1;
      repeat (gap - 1) begin
        @(negedge clk);
        sample_strobe = 1'b0;
      end
    end
  endtask

  task automatic end_strobes();
    @(negedge clk);
    sample_strobe = 1'b0;
  endtask

  task automatic check_frames(input int n_frames);
    bin_t b;
    real  want;
    real  peak;
    int   waited;
    int   k;
    waited = 0;
    k = 0;
    while (rx_q.size() < n_frames * N_SAMPLES && waited < 16 * n_frames + 32) begin
      @(negedge clk);
      waited++;
    end
    assert (rx_q.size() >= n_frames * N_SAMPLES) else begin
      errors++;
      $display("Bins missing, got %0d of %0d", rx_q.size(), n_frames * N_SAMPLES);
    end
    while (rx_q.size() > 0 && exp_q.size() > 0) begin
      b = rx_q.pop_front();
      want = exp_q.pop_front();
      peak = peak_q.pop_front();
      checks++;
      assert (within_tolerance(real'(b.power), want, peak)) else begin
        errors++;
        $display("[ERROR] t=%0t bin %0d power %0d, expected %0.0f", $time, k, b.power, want);
      end
      assert (b.index == BIN_W'(k) && b.last == (k == N_SAMPLES - 1)) else begin
        errors++;
        $display("[ERROR] t=%0t bin %0d arrived as index %0d last %0b",
                 $time, k, b.index, b.last);
      end
      last_pow[k] = longint'(b.power);
      k = (k + 1) % N_SAMPLES;
    end
    rx_q.delete();
    exp_q.delete();
    peak_q.delete();
  endtask

  task automatic impulse_test();
    int x[N_SAMPLES];
    foreach (x[j]) x[j] = (j == 0) ? 1000 : 0;
    send_frame(x, 1);
    end_strobes();
    check_frames(1);
  endtask

  task automatic dc_test();
    int x[N_SAMPLES];
    foreach (x[j]) x[j] = 500;
    send_frame(x, 1);
    end_strobes();
    check_frames(1);
  endtask

  task automatic tone_test();
    int x[N_SAMPLES];
    foreach (x[j]) x[j] = int'(2000.0 * $cos(2.0 * PI * j / N_SAMPLES));
    send_frame(x, 1);
    end_strobes();
    check_frames(1);
    // Mirror bins of a real tone.
    assert (within_tolerance(real'(last_pow[1]), real'(last_pow[7]), real'(last_pow[1])))
    else begin
      errors++;
      $display("[ERROR] t=%0t tone bins differ, %0d vs %0d", $time, last_pow[1], last_pow[7]);
    end
  endtask

  task automatic random_test();
    int x[N_SAMPLES];
    repeat (6) begin
      foreach (x[j]) x[j] = random_sample();
      send_frame(x, 2);
    end
    check_frames(6);
    assert (!overflow) else begin
      errors++;
      $display("[ERROR] t=%0t overflow raised at one strobe every two cycles", $time);
    end
  endtask

  task automatic latency_test();
    int x[N_SAMPLES];
    int strobe_cycle;
    foreach (x[j]) x[j] = 100 * j - 300;
    send_frame(x, 1);
    strobe_cycle = cycle + 1;  // Edge that samples the 8th strobe.
    end_strobes();
    while (!bin_val && cycle - strobe_cycle < 4 * LATENCY) @(negedge clk);
    assert (cycle - strobe_cycle == LATENCY) else begin
      errors++;
      $display("[ERROR] t=%0t latency %0d cycles, expected %0d",
               $time, cycle - strobe_cycle, LATENCY);
    end
    check_frames(1);
  endtask

  // Prior frame streams while two more arrive back to back.
  task automatic overflow_test();
    int x[N_SAMPLES];
    int waited;
    int got;
    do_reset();
    repeat (3) begin
      foreach (x[j]) x[j] = random_sample();
      send_frame(x, 1);
    end
    end_strobes();
    waited = 0;
    while (rx_q.size() < 3 * N_SAMPLES && waited < 48) begin
      @(negedge clk);
      waited++;
    end
    got = rx_q.size();
    assert (overflow == (got < 3 * N_SAMPLES)) else begin
      errors++;
      $display("[ERROR] t=%0t overflow %0b with %0d of %0d bins out",
               $time, overflow, got, 3 * N_SAMPLES);
    end
    rx_q.delete();
    exp_q.delete();
    peak_q.delete();
  endtask

  initial begin
    sample = '0;
    sample_strobe = 1'b0;
    do_reset();
    impulse_test();
    dc_test();
    tone_test();
    random_test();
    latency_test();
    overflow_test();
    $display("Bin checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- logic/spectrum_top.sv
`default_nettype none

module spectrum_top
  import fxp_pkg::*;
  import fft_pkg::*;
(
  input  wire logic    clk,
  input  wire logic    reset,
  input  wire sample_t sample,
  input  wire logic    sample_strobe,
  output bin_t         bin,
  output logic         bin_val,
  output logic         overflow
);

  frame_t frame;
  logic   frame_val;
  logic   frame_rdy;
  frame_t spec;
  logic   spec_val;
  logic   spec_rdy;

  sample_framer u_framer (
    .clk          (clk),
    .reset        (reset),
    .sample       (sample),
    .sample_strobe(sample_strobe),
    .frame_rdy    (frame_rdy),
    .frame        (frame),
    .frame_val    (frame_val),
    .overflow     (overflow)
  );

  fft_pease_core u_fft (
    .clk      (clk),
    .reset    (reset),
    .frame    (frame),
    .frame_val(frame_val),
    .frame_rdy(frame_rdy),
    .spec     (spec),
    .spec_val (spec_val),
    .spec_rdy (spec_rdy)
  );

  power_spectrum u_power (
    .clk     (clk),
    .reset   (reset),
    .spec    (spec),
    .spec_val(spec_val),
    .spec_rdy(spec_rdy),
    .bin     (bin),
    .bin_val (bin_val)
  );

endmodule

`default_nettype wire

//--- logic/power_spectrum.sv
`default_nettype none

module power_spectrum
  import fxp_pkg::*;
  import fft_pkg::*;
(
  input  wire logic   clk,
  input  wire logic   reset,
  input  wire frame_t spec,
  input  wire logic   spec_val,
  output logic        spec_rdy,
  output bin_t        bin,
  output logic        bin_val
);

  frame_t hold;
  logic busy;
  logic [BIN_W-1:0] idx;
  logic take;
  cplx_t sel;
  logic signed [2*DATA_W:0] mag2;

  assign spec_rdy = !busy;
  assign take     = spec_val && spec_rdy;
  assign sel      = hold[idx];
  assign mag2     = sel.re * sel.re + sel.im * sel.im;  // Q32.32.

  always_ff @(posedge clk) begin
    if (reset) begin
      busy    <= 1'b0;
      idx     <= '0;
      bin_val <= 1'b0;
    end else begin
      bin_val <= busy;
      if (take) begin
        busy <= 1'b1;
        idx  <= '0;
      end else if (busy) begin
        idx <= idx + 1'b1;
        if (idx == BIN_W'(N_SAMPLES - 1)) busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) hold <= spec;
    if (busy) begin
      bin <= '{
        index: idx,
        power: POWER_W'(mag2 >>> FRAC_W),
        last:  idx == BIN_W'(N_SAMPLES - 1)
      };
    end
  end

  // Bins count up and the stream stops right after the last one.
  a_last_bin: assert property (@(posedge clk) disable iff (reset)
    bin_val |=> (bin_val != $past(bin.last)) &&
                (!bin_val || bin.index == $past(bin.index) + 1'b1))
    else $error("bin stream out of order at index %0d", bin.index);

  // A transfer holds off the core for one full frame of bins.
  a_stream: assert property (@(posedge clk) disable iff (reset)
    take |=> (!spec_rdy [*N_SAMPLES]) and (##1 bin_val [*N_SAMPLES]))
    else $error("bin stream broken");

endmodule

`default_nettype wire

//--- logic/sample_framer.sv
`default_nettype none

module sample_framer
  import fxp_pkg::*;
  import fft_pkg::*;
(
  input  wire logic    clk,
  input  wire logic    reset,
  input  wire sample_t sample,
  input  wire logic    sample_strobe,
  input  wire logic    frame_rdy,
  output frame_t       frame,
  output logic         frame_val,
  output logic         overflow
);

  logic [BIN_W-1:0] wr_cnt;  // Wraps after the last sample.

  always_ff @(posedge clk) begin
    if (sample_strobe) begin
      frame[wr_cnt] <= '{re: fxp_t'(sample) <<< FRAC_W, im: '0};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_cnt    <= '0;
      frame_val <= 1'b0;
      overflow  <= 1'b0;
    end else begin
      frame_val <= sample_strobe && (wr_cnt == BIN_W'(N_SAMPLES - 1));
      if (sample_strobe) wr_cnt <= wr_cnt + 1'b1;
      // Core busy, frame lost.
      if (frame_val && !frame_rdy) overflow <= 1'b1;
    end
  end

  a_val_pulse: assert property (@(posedge clk) disable iff (reset) frame_val |=> !frame_val)
    else $error("frame_val held for two cycles");

endmodule

`default_nettype wire

//--- logic/fft_pease_core.sv
`default_nettype none

module fft_pease_core
  import fxp_pkg::*;
  import fft_pkg::*;
(
  input  wire logic   clk,
  input  wire logic   reset,
  input  wire frame_t frame,
  input  wire logic   frame_val,
  output logic        frame_rdy,
  output frame_t      spec,
  output logic        spec_val,
  input  wire logic   spec_rdy
);

  typedef enum logic [1:0] {IDLE, COMP, DONE} state_t;

  state_t state;
  state_t state_nxt;
  logic [STAGE_W-1:0] stage;
  logic [STAGE_W-1:0] stage_nxt;
  logic take_in;

  frame_t work;     // Working register, also the result.
  frame_t rev;
  frame_t bf_out;
  frame_t perm;
  logic [N_SAMPLES/2-1:0][DATA_W-1:0] wr;
  logic [N_SAMPLES/2-1:0][DATA_W-1:0] wi;

  function automatic logic [BIN_W-1:0] bit_rev(input logic [BIN_W-1:0] k);
    for (int b = 0; b < BIN_W; b++) begin
      bit_rev[b] = k[BIN_W-1-b];
    end
  endfunction

  assign frame_rdy = (state == IDLE) || (state == DONE && spec_rdy);
  assign spec_val  = (state == DONE);
  assign spec      = work;
  assign take_in   = frame_val && frame_rdy;

  twiddle_rom #(.N_POINTS(N_SAMPLES)) u_twiddle (
    .stage(stage),
    .wr   (wr),
    .wi   (wi)
  );

  butterfly_array #(.N_POINTS(N_SAMPLES)) u_bfly (
    .clk  (clk),
    .a_in (work),
    .wr   (wr),
    .wi   (wi),
    .y_out(bf_out)
  );

  // Bit reversal on load, stride-2 permutation after each rank.
  always_comb begin
    for (int k = 0; k < N_SAMPLES; k++) begin
      rev[k] = frame[bit_rev(BIN_W'(k))];
    end
    for (int i = 0; i < N_SAMPLES / 2; i++) begin
      perm[i]               = bf_out[2*i];
      perm[i+N_SAMPLES/2]   = bf_out[2*i+1];
    end
  end

  always_comb begin
    state_nxt = state;
    stage_nxt = stage;
    case (state)
      IDLE: if (take_in) state_nxt = COMP;
      COMP: begin
        if (stage == STAGE_W'(N_STAGES - 1)) begin
          state_nxt = DONE;
          stage_nxt = '0;
        end else begin
          stage_nxt = stage + 1'b1;
        end
      end
      DONE: if (spec_rdy) state_nxt = take_in ? COMP : IDLE;  // Back to back.
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      stage <= '0;
    end else begin
      state <= state_nxt;
      stage <= stage_nxt;
    end
  end

  always_ff @(posedge clk) begin
    if (take_in) work <= rev;
    else if (state == COMP) work <= perm;
  end

  a_spec_stable: assert property (@(posedge clk) disable iff (reset)
    (spec_val && !spec_rdy) |=> (spec_val && $stable(spec)))
    else $error("spec changed while stalled");

  a_stage_range: assert property (@(posedge clk) disable iff (reset) stage < N_STAGES)
    else $error("stage counter out of range");

endmodule

`default_nettype wire

//--- logic/butterfly_array.sv
`default_nettype none

module butterfly_array
  import fxp_pkg::*;
#(
  parameter int N_POINTS = 8
) (
  input  wire logic                                clk,
  input  wire cplx_t [N_POINTS-1:0]                a_in,
  input  wire logic [N_POINTS/2-1:0][DATA_W-1:0]   wr,
  input  wire logic [N_POINTS/2-1:0][DATA_W-1:0]   wi,
  output cplx_t [N_POINTS-1:0]                     y_out
);

  localparam int HALF = N_POINTS / 2;

  logic [HALF-1:0] ovf;

  for (genvar i = 0; i < HALF; i++) begin : g_bfly
    cplx_t a;
    cplx_t b;
    logic signed [2*DATA_W:0] prod_re;
    logic signed [2*DATA_W:0] prod_im;
    fxp_t wb_re;
    fxp_t wb_im;
    logic signed [DATA_W:0] sum_re;
    logic signed [DATA_W:0] sum_im;
    logic signed [DATA_W:0] dif_re;
    logic signed [DATA_W:0] dif_im;

    assign a = a_in[2*i];
    assign b = a_in[2*i+1];

    // Full precision w*b, back to Q16.16.
    assign prod_re = $signed(wr[i]) * b.re - $signed(wi[i]) * b.im;
    assign prod_im = $signed(wr[i]) * b.im + $signed(wi[i]) * b.re;
    assign wb_re   = fxp_t'(prod_re >>> FRAC_W);
    assign wb_im   = fxp_t'(prod_im >>> FRAC_W);

    assign sum_re = a.re + wb_re;
    assign sum_im = a.im + wb_im;
    assign dif_re = a.re - wb_re;
    assign dif_im = a.im - wb_im;

    assign y_out[2*i]   = '{re: sum_re[DATA_W-1:0], im: sum_im[DATA_W-1:0]};
    assign y_out[2*i+1] = '{re: dif_re[DATA_W-1:0], im: dif_im[DATA_W-1:0]};

    // Sign bit and carry disagree on overflow.
    assign ovf[i] = (sum_re[DATA_W] ^ sum_re[DATA_W-1]) | (sum_im[DATA_W] ^ sum_im[DATA_W-1]) |
                    (dif_re[DATA_W] ^ dif_re[DATA_W-1]) | (dif_im[DATA_W] ^ dif_im[DATA_W-1]);
  end

  a_no_overflow: assert property (@(posedge clk) ovf == '0)
    else $error("butterfly sum overflow, pairs %b", ovf);

endmodule

`default_nettype wire

//--- logic/twiddle_rom.sv
`default_nettype none

module twiddle_rom
  import fxp_pkg::*;
#(
  parameter int N_POINTS = 8
) (
  input  wire logic [$clog2($clog2(N_POINTS))-1:0] stage,
  output logic [N_POINTS/2-1:0][DATA_W-1:0]        wr,
  output logic [N_POINTS/2-1:0][DATA_W-1:0]        wi
);

  localparam int STAGES = $clog2(N_POINTS);
  localparam int HALF   = N_POINTS / 2;

  typedef logic [HALF-1:0][DATA_W-1:0] row_t;
  typedef row_t [STAGES-1:0] table_t;

  // Taylor series; angles stay below pi so a dozen terms is plenty.
  function automatic fxp_t trig_q(input int m, input bit want_sin);
    real x;
    real term;
    real acc;
    x = 2.0 * 3.14159265358979 * m / N_POINTS;
    term = want_sin ? x : 1.0;
    acc = term;
    for (int k = 1; k <= 12; k++) begin
      term = -term * x * x / ((2 * k - 1 + want_sin) * (2 * k + want_sin));
      acc += term;
    end
    return fxp_t'(longint'(acc * (2.0 ** FRAC_W)));  // Rounds to nearest.
  endfunction

  function automatic table_t build_table(input bit want_sin);
    table_t t;
    int m;
    for (int s = 0; s < STAGES; s++) begin
      for (int i = 0; i < HALF; i++) begin
        m = (i >> (STAGES - 1 - s)) << (STAGES - 1 - s);
        t[s][i] = want_sin ? -trig_q(m, 1'b1) : trig_q(m, 1'b0);
      end
    end
    return t;
  endfunction

  localparam table_t WR_TABLE = build_table(1'b0);
  localparam table_t WI_TABLE = build_table(1'b1);  // Already negated.

  assign wr = WR_TABLE[stage];
  assign wi = WI_TABLE[stage];

  always_comb begin
    assert (stage < STAGES) else $error("twiddle stage %0d out of range", stage);
  end

endmodule

`default_nettype wire

//--- logic/fft_pkg.sv
`default_nettype none

package fft_pkg;

  import fxp_pkg::*;

  localparam int N_SAMPLES = 8;
  localparam int N_STAGES  = $clog2(N_SAMPLES);
  localparam int STAGE_W   = 2;
  localparam int BIN_W     = $clog2(N_SAMPLES);

  // Element k is sample k, or bin k after the transform.
  typedef cplx_t [N_SAMPLES-1:0] frame_t;

  typedef struct packed {
    logic [BIN_W-1:0]   index;
    logic [POWER_W-1:0] power;
    logic               last;  // Set on the final bin of a frame.
  } bin_t;

endpackage

`default_nettype wire

//--- logic/fxp_pkg.sv
`default_nettype none

package fxp_pkg;

  localparam int DATA_W   = 32;  // One real or imaginary part.
  localparam int FRAC_W   = 16;  // Q16.16.
  localparam int SAMPLE_W = 16;  // Signed integer samples.
  localparam int POWER_W  = 48;

  typedef logic signed [DATA_W-1:0] fxp_t;
  typedef logic signed [SAMPLE_W-1:0] sample_t;

  typedef struct packed {
    fxp_t re;
    fxp_t im;
  } cplx_t;

endpackage

`default_nettype wire
